/* rtl/fifo_pkg.sv */
package fifo_pkg;

   // flag values out of the asynchronous reset
   localparam logic EMPTY_RST = 1'b1;
   localparam logic FULL_RST  = 1'b0;

   function automatic int max_w(input int a, input int b);
      return (a > b) ? a : b;
   endfunction

   function automatic int min_w(input int a, input int b);
      return (a < b) ? a : b;
   endfunction

   // log2 of the port width ratio, 0 for equal widths
   function automatic int ratio_log2(input int a, input int b);
      int ratio;
      int lg;
      ratio = max_w(a, b) / min_w(a, b);
      lg = 0;
      while ((1 << lg) < ratio) begin
         lg++;
      end
      return lg;
   endfunction

endpackage

/* rtl/ram_2p.sv */
`timescale 1ns/1ps

module ram_2p #(
   parameter int DATA_W = 8,
   parameter int ADDR_W = 4
) (
   input  logic              clk_i,

   // write port
   input  logic              w_en_i,
   input  logic [ADDR_W-1:0] w_addr_i,
   input  logic [DATA_W-1:0] w_data_i,

   // read port
   input  logic              r_en_i,
   input  logic [ADDR_W-1:0] r_addr_i,
   output logic [DATA_W-1:0] r_data_o
);

   localparam int DEPTH = 2 ** ADDR_W;

   logic [DATA_W-1:0] mem [DEPTH];

   always_ff @(posedge clk_i) begin
      if (w_en_i) begin
         mem[w_addr_i] <= w_data_i;
      end
   end

   // registered read, holds between read strobes
   always_ff @(posedge clk_i) begin
      if (r_en_i) begin
         r_data_o <= mem[r_addr_i];
      end
   end

endmodule

/* rtl/ram_2p_asym.sv */
`timescale 1ns/1ps

module ram_2p_asym
   import fifo_pkg::*;
#(
   parameter int W_DATA_W = 8,
   parameter int R_DATA_W = 32,
   parameter int ADDR_W   = 6,

   localparam int MAXDATA_W  = max_w(W_DATA_W, R_DATA_W),
   localparam int MINDATA_W  = min_w(W_DATA_W, R_DATA_W),
   localparam int RATIO_LOG2 = ratio_log2(W_DATA_W, R_DATA_W),
   localparam int N          = 2 ** RATIO_LOG2,
   localparam int MINADDR_W  = ADDR_W - RATIO_LOG2,
   localparam int W_ADDR_W   = (W_DATA_W == MAXDATA_W) ? MINADDR_W : ADDR_W,
   localparam int R_ADDR_W   = (R_DATA_W == MAXDATA_W) ? MINADDR_W : ADDR_W
) (
   input  logic                     clk_i,
   input  logic                     arst_n_i,

   // fifo side
   input  logic                     w_en_i,
   input  logic [W_ADDR_W-1:0]      w_addr_i,
   input  logic [W_DATA_W-1:0]      w_data_i,
   input  logic                     r_en_i,
   input  logic [R_ADDR_W-1:0]      r_addr_i,
   output logic [R_DATA_W-1:0]      r_data_o,

   // bank side
   output logic [N-1:0]             ext_mem_w_en_o,
   output logic [N*MINADDR_W-1:0]   ext_mem_w_addr_o,
   output logic [N*MINDATA_W-1:0]   ext_mem_w_data_o,
   output logic                     ext_mem_r_en_o,
   output logic [N*MINADDR_W-1:0]   ext_mem_r_addr_o,
   input  logic [N*MINDATA_W-1:0]   ext_mem_r_data_i
);

   // write side
   if (W_DATA_W == MAXDATA_W) begin : g_w_wide
      // every bank takes its own slice
      assign ext_mem_w_en_o   = {N{w_en_i}};
      assign ext_mem_w_addr_o = {N{w_addr_i}};
      assign ext_mem_w_data_o = w_data_i;
   end else begin : g_w_narrow
      logic [RATIO_LOG2-1:0] w_sel;

      // low pointer bits pick the bank
      assign w_sel            = w_addr_i[RATIO_LOG2-1:0];
      assign ext_mem_w_en_o   = {{(N-1){1'b0}}, w_en_i} << w_sel;
      assign ext_mem_w_addr_o = {N{w_addr_i[W_ADDR_W-1:RATIO_LOG2]}};
      assign ext_mem_w_data_o = {N{w_data_i}};
   end

   assign ext_mem_r_en_o = r_en_i;

   // read side
   if (R_DATA_W == MAXDATA_W) begin : g_r_wide
      assign ext_mem_r_addr_o = {N{r_addr_i}};
      // bank 0 lands in the low bits
      assign r_data_o         = ext_mem_r_data_i;
   end else begin : g_r_narrow
      logic [RATIO_LOG2-1:0] r_sel_q;

      assign ext_mem_r_addr_o = {N{r_addr_i[R_ADDR_W-1:RATIO_LOG2]}};

      // bank select lines up with the registered bank output
      always_ff @(posedge clk_i or negedge arst_n_i) begin
         if (!arst_n_i) begin
            r_sel_q <= '0;
         end else if (r_en_i) begin
            r_sel_q <= r_addr_i[RATIO_LOG2-1:0];
         end
      end

      assign r_data_o = ext_mem_r_data_i[r_sel_q*MINDATA_W +: MINDATA_W];
   end

endmodule

/* rtl/fifo_sync.sv */
`timescale 1ns/1ps

module fifo_sync
   import fifo_pkg::*;
#(
   parameter int W_DATA_W = 8,
   parameter int R_DATA_W = 32,
   parameter int ADDR_W   = 6,

   localparam int MAXDATA_W  = max_w(W_DATA_W, R_DATA_W),
   localparam int MINDATA_W  = min_w(W_DATA_W, R_DATA_W),
   localparam int RATIO_LOG2 = ratio_log2(W_DATA_W, R_DATA_W),
   localparam int N          = 2 ** RATIO_LOG2,
   localparam int MINADDR_W  = ADDR_W - RATIO_LOG2,
   localparam int W_ADDR_W   = (W_DATA_W == MAXDATA_W) ? MINADDR_W : ADDR_W,
   localparam int R_ADDR_W   = (R_DATA_W == MAXDATA_W) ? MINADDR_W : ADDR_W
) (
   input  logic                     clk_i,
   input  logic                     arst_n_i,
   input  logic                     rst_i,

   // write port
   input  logic                     w_en_i,
   input  logic [W_DATA_W-1:0]      w_data_i,
   output logic                     w_full_o,

   // read port
   input  logic                     r_en_i,
   output logic [R_DATA_W-1:0]      r_data_o,
   output logic                     r_empty_o,

   // occupancy in narrow units
   output logic [ADDR_W:0]          level_o,

   // memory banks
   output logic [N-1:0]             ext_mem_w_en_o,
   output logic [N*MINADDR_W-1:0]   ext_mem_w_addr_o,
   output logic [N*MINDATA_W-1:0]   ext_mem_w_data_o,
   output logic                     ext_mem_r_en_o,
   output logic [N*MINADDR_W-1:0]   ext_mem_r_addr_o,
   input  logic [N*MINDATA_W-1:0]   ext_mem_r_data_i
);

   localparam logic [ADDR_W+1:0] FIFO_SIZE = (ADDR_W+2)'(1) << ADDR_W;

   // a wide access moves N narrow units
   localparam logic [ADDR_W+1:0] W_INCR =
      (W_DATA_W > R_DATA_W) ? (ADDR_W+2)'(N) : (ADDR_W+2)'(1);
   localparam logic [ADDR_W+1:0] R_INCR =
      (R_DATA_W > W_DATA_W) ? (ADDR_W+2)'(N) : (ADDR_W+2)'(1);

   logic                w_en_int;
   logic                r_en_int;
   logic [W_ADDR_W-1:0] w_addr;
   logic [R_ADDR_W-1:0] r_addr;
   logic [ADDR_W+1:0]   level_nxt;
   logic                r_empty_nxt;
   logic                w_full_nxt;

   // strobes that hit a flag are dropped
   assign w_en_int = w_en_i & ~w_full_o;
   assign r_en_int = r_en_i & ~r_empty_o;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         w_addr <= '0;
      end else if (rst_i) begin
         w_addr <= '0;
      end else if (w_en_int) begin
         w_addr <= w_addr + W_ADDR_W'(1);
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         r_addr <= '0;
      end else if (rst_i) begin
         r_addr <= '0;
      end else if (r_en_int) begin
         r_addr <= r_addr + R_ADDR_W'(1);
      end
   end

   always_comb begin
      level_nxt = {1'b0, level_o};
      if (w_en_int) begin
         level_nxt = level_nxt + W_INCR;
      end
      if (r_en_int) begin
         level_nxt = level_nxt - R_INCR;
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         level_o <= '0;
      end else if (rst_i) begin
         level_o <= '0;
      end else begin
         level_o <= level_nxt[ADDR_W:0];
      end
   end

   // flags come from the next level, rst_i reaches them through level_o
   assign r_empty_nxt = level_nxt < R_INCR;
   assign w_full_nxt  = level_nxt > (FIFO_SIZE - W_INCR);

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         r_empty_o <= EMPTY_RST;
         w_full_o  <= FULL_RST;
      end else begin
         r_empty_o <= r_empty_nxt;
         w_full_o  <= w_full_nxt;
      end
   end

   ram_2p_asym #(
      .W_DATA_W (W_DATA_W),
      .R_DATA_W (R_DATA_W),
      .ADDR_W   (ADDR_W)
   ) i_ram_2p_asym (
      .clk_i            (clk_i),
      .arst_n_i         (arst_n_i),
      .w_en_i           (w_en_int),
      .w_addr_i         (w_addr),
      .w_data_i         (w_data_i),
      .r_en_i           (r_en_int),
      .r_addr_i         (r_addr),
      .r_data_o         (r_data_o),
      .ext_mem_w_en_o   (ext_mem_w_en_o),
      .ext_mem_w_addr_o (ext_mem_w_addr_o),
      .ext_mem_w_data_o (ext_mem_w_data_o),
      .ext_mem_r_en_o   (ext_mem_r_en_o),
      .ext_mem_r_addr_o (ext_mem_r_addr_o),
      .ext_mem_r_data_i (ext_mem_r_data_i)
   );

   a_level_max: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      level_o <= FIFO_SIZE
   ) else $error("level above fifo size");

   // room for a whole write unit whenever one is taken
   a_no_write_full: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      w_en_int |-> ({1'b0, level_o} <= (FIFO_SIZE - W_INCR))
   ) else $error("write accepted with no room left");

endmodule

/* rtl/fifo_top.sv */
`timescale 1ns/1ps

module fifo_top
   import fifo_pkg::*;
#(
   parameter int W_DATA_W = 8,
   parameter int R_DATA_W = 32,
   parameter int ADDR_W   = 6
) (
   input  logic                clk_i,
   input  logic                arst_n_i,
   input  logic                rst_i,

   input  logic                w_en_i,
   input  logic [W_DATA_W-1:0] w_data_i,
   output logic                w_full_o,

   input  logic                r_en_i,
   output logic [R_DATA_W-1:0] r_data_o,
   output logic                r_empty_o,

   output logic [ADDR_W:0]     level_o
);

   // bank geometry
   localparam int MINDATA_W  = min_w(W_DATA_W, R_DATA_W);
   localparam int RATIO_LOG2 = ratio_log2(W_DATA_W, R_DATA_W);
   localparam int N          = max_w(W_DATA_W, R_DATA_W) / MINDATA_W;
   localparam int MINADDR_W  = ADDR_W - RATIO_LOG2;

   logic [N-1:0]           ext_mem_w_en;
   logic [N*MINADDR_W-1:0] ext_mem_w_addr;
   logic [N*MINDATA_W-1:0] ext_mem_w_data;
   logic                   ext_mem_r_en;
   logic [N*MINADDR_W-1:0] ext_mem_r_addr;
   logic [N*MINDATA_W-1:0] ext_mem_r_data;

   fifo_sync #(
      .W_DATA_W (W_DATA_W),
      .R_DATA_W (R_DATA_W),
      .ADDR_W   (ADDR_W)
   ) i_fifo_sync (
      .clk_i            (clk_i),
      .arst_n_i         (arst_n_i),
      .rst_i            (rst_i),
      .w_en_i           (w_en_i),
      .w_data_i         (w_data_i),
      .w_full_o         (w_full_o),
      .r_en_i           (r_en_i),
      .r_data_o         (r_data_o),
      .r_empty_o        (r_empty_o),
      .level_o          (level_o),
      .ext_mem_w_en_o   (ext_mem_w_en),
      .ext_mem_w_addr_o (ext_mem_w_addr),
      .ext_mem_w_data_o (ext_mem_w_data),
      .ext_mem_r_en_o   (ext_mem_r_en),
      .ext_mem_r_addr_o (ext_mem_r_addr),
      .ext_mem_r_data_i (ext_mem_r_data)
   );

   // one narrow bank per slice, bank 0 in the low bits
   for (genvar i = 0; i < N; i++) begin : g_bank
      ram_2p #(
         .DATA_W (MINDATA_W),
         .ADDR_W (MINADDR_W)
      ) i_ram_2p (
         .clk_i    (clk_i),
         .w_en_i   (ext_mem_w_en[i]),
         .w_addr_i (ext_mem_w_addr[i*MINADDR_W +: MINADDR_W]),
         .w_data_i (ext_mem_w_data[i*MINDATA_W +: MINDATA_W]),
         .r_en_i   (ext_mem_r_en),
         .r_addr_i (ext_mem_r_addr[i*MINADDR_W +: MINADDR_W]),
         .r_data_o (ext_mem_r_data[i*MINDATA_W +: MINDATA_W])
      );
   end

endmodule

/* dv/tb_fifo_top.sv */
`timescale 1ns/1ps

module tb_fifo_top;

   localparam int W_DATA_W = 8;
   localparam int R_DATA_W = 32;
   localparam int ADDR_W   = 6;
   localparam int LEVEL_W  = ADDR_W + 1;

   localparam logic [ADDR_W:0] FIFO_BYTES     = LEVEL_W'(64);
   localparam logic [ADDR_W:0] BYTES_PER_WORD = LEVEL_W'(4);

   localparam int FILL_CYCLES    = 80;
   localparam int DRAIN_CYCLES   = 20;
   localparam int RANDOM_CYCLES  = 1800;
   localparam int TIMEOUT_CYCLES = 4000;

   logic                clk_i;
   logic                arst_n_i;
   logic                rst_i;
   logic                w_en_i;
   logic [W_DATA_W-1:0] w_data_i;
   logic                w_full_o;
   logic                r_en_i;
   logic [R_DATA_W-1:0] r_data_o;
   logic                r_empty_o;
   logic [ADDR_W:0]     level_o;

   // reference model state
   logic [W_DATA_W-1:0] ref_q[$];
   logic [ADDR_W:0]     model_level;
   logic [ADDR_W:0]     level_nxt;
   logic [R_DATA_W-1:0] exp_word;
   logic [R_DATA_W-1:0] word;
   logic                word_due;
   logic                clr_d;
   logic                w_acc;
   logic                r_acc;

   int seed;
   int cycle_cnt;

   fifo_top i_fifo_top (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .rst_i     (rst_i),
      .w_en_i    (w_en_i),
      .w_data_i  (w_data_i),
      .w_full_o  (w_full_o),
      .r_en_i    (r_en_i),
      .r_data_o  (r_data_o),
      .r_empty_o (r_empty_o),
      .level_o   (level_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Done: errors found");
      $fatal(1, "simulation stopped");
   endtask

   task automatic report_error(input string msg);
      abort_run($sformatf("Error at %0t ns: %s", $time, msg));
   endtask

   task automatic drive_cycle(input logic w, input logic r, input logic clr);
      @(negedge clk_i);
      w_en_i   = w;
      w_data_i = W_DATA_W'($random(seed));
      r_en_i   = r;
      rst_i    = clr;
   endtask

   // byte queue, words leave with the oldest byte in the low bits
   always @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ref_q.delete();
         model_level <= '0;
         exp_word    <= '0;
         word_due    <= 1'b0;
         clr_d       <= 1'b0;
      end else begin
         clr_d    <= rst_i;
         word_due <= 1'b0;
         if (rst_i) begin
            ref_q.delete();
            model_level <= '0;
         end else begin
            w_acc     = w_en_i && (model_level != FIFO_BYTES);
            r_acc     = r_en_i && (model_level >= BYTES_PER_WORD);
            level_nxt = model_level;
            if (r_acc) begin
               for (int k = 0; k < 4; k++) begin
                  word[k*W_DATA_W +: W_DATA_W] = ref_q.pop_front();
               end
               exp_word  <= word;
               word_due  <= 1'b1;
               level_nxt = level_nxt - BYTES_PER_WORD;
            end
            if (w_acc) begin
               ref_q.push_back(w_data_i);
               level_nxt = level_nxt + LEVEL_W'(1);
            end
            model_level <= level_nxt;
         end
      end
   end

   a_reset_values: assert property (
      @(posedge clk_i) $rose(arst_n_i) |-> (level_o == '0 && r_empty_o && !w_full_o)
   ) else report_error("flags or level wrong after reset");

   a_level: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      level_o == model_level
   ) else report_error("level_o differs from accepted bytes minus read words");

   a_read_data: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      word_due |-> (r_data_o == exp_word)
   ) else report_error("r_data_o does not match the next four queued bytes");

   // flags lag level_o by one cycle after a clear
   a_full_rule: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      !clr_d |-> (w_full_o == (level_o == FIFO_BYTES))
   ) else report_error("w_full_o does not follow level_o");

   a_empty_rule: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      !clr_d |-> (r_empty_o == (level_o < BYTES_PER_WORD))
   ) else report_error("r_empty_o does not follow level_o");

   a_write_full_hold: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      (w_en_i && w_full_o && !r_en_i && !rst_i) |=> $stable(level_o)
   ) else report_error("write while full changed level_o");

   a_read_empty_hold: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      (r_en_i && r_empty_o && !w_en_i && !rst_i) |=> $stable(level_o)
   ) else report_error("read while empty changed level_o");

   a_clear_level: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      rst_i |=> (level_o == '0)
   ) else report_error("level_o not zero after rst_i");

   a_clear_empty: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      clr_d |=> r_empty_o
   ) else report_error("r_empty_o not set one cycle after clear");

   always @(posedge clk_i) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt == TIMEOUT_CYCLES) begin
         abort_run("Timeout: the stimulus did not finish within the cycle limit");
      end
   end

   initial begin
      logic w_pick;
      logic r_pick;

      seed      = 32'haf6f_bfc9;
      cycle_cnt = 0;
      arst_n_i  = 1'b0;
      rst_i     = 1'b0;
      w_en_i    = 1'b0;
      w_data_i  = '0;
      r_en_i    = 1'b0;

      repeat (2) @(negedge clk_i);
      arst_n_i = 1'b1;

      // fill past full, the last writes are dropped
      repeat (FILL_CYCLES) drive_cycle(1'b1, 1'b0, 1'b0);

      // drain past empty
      repeat (DRAIN_CYCLES) drive_cycle(1'b0, 1'b1, 1'b0);

      // alternate between filling and draining blocks of 200 cycles
      for (int i = 0; i < RANDOM_CYCLES; i++) begin
         if (i == 600 || i == 1000) begin
            drive_cycle(1'b0, 1'b0, 1'b1);
            drive_cycle(1'b0, 1'b0, 1'b0);
         end else begin
            if (((i / 200) % 2) == 0) begin
               w_pick = ($random(seed) & 3) != 0;
               r_pick = ($random(seed) & 7) == 0;
            end else begin
               w_pick = ($random(seed) & 3) == 0;
               r_pick = ($random(seed) & 1) != 0;
            end
            drive_cycle(w_pick, r_pick, 1'b0);
         end
      end

      // let the last read word reach its check
      drive_cycle(1'b0, 1'b0, 1'b0);
      drive_cycle(1'b0, 1'b0, 1'b0);
      @(negedge clk_i);
      $display("Done: no errors");
      $finish;
   end

endmodule

/* sources.f */
rtl/fifo_pkg.sv
rtl/ram_2p.sv
rtl/ram_2p_asym.sv
rtl/fifo_sync.sv
rtl/fifo_top.sv
dv/tb_fifo_top.sv

/* Makefile */
TOP := tb_fifo_top

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f sources.f --Mdir obj_dir -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf obj_dir
